/* common/core_pkg.sv */
package core_pkg;

    localparam int unsigned XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // memory map, address bits 19..16 and 4..2
    localparam logic [3:0] MMIO_RANGE = 4'h8;
    localparam logic [2:0] UART_TX_OFFSET = 3'd0;

    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MCYCLE = 12'hB00;
    localparam logic [11:0] CSR_MINSTRET = 12'hB02;
    localparam logic [11:0] CSR_MCYCLEH = 12'hB80;
    localparam logic [11:0] CSR_MINSTRETH = 12'hB82;

    localparam logic [6:0] OP = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] LUI = 7'b0110111;
    localparam logic [6:0] JAL = 7'b1101111;
    localparam logic [6:0] BRANCH = 7'b1100011;
    localparam logic [6:0] STORE = 7'b0100011;
    localparam logic [6:0] SYSTEM = 7'b1110011;

    // one instruction word, seen through each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0] rd;
            logic [6:0] opcode;
        } u;
        struct packed {
            logic imm20;
            logic [9:0] imm10_1;
            logic imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_CSR} wb_sel_e;

    // encoding matches funct3[1:0] of the csr instructions
    typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic uses_imm;
        logic rd_we;
        logic is_branch;
        logic is_jump;
        logic is_store;
        csr_op_e csr_op;
        logic csr_uses_imm;
        wb_sel_e wb_sel;
    } decoded_t;

    typedef struct packed {
        logic valid;
        logic [XLEN-1:0] pc;
        inst_u inst;
        decoded_t decoded;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
    } dec_exe_t;

    typedef struct packed {
        logic valid;
        logic [11:0] addr;
        csr_op_e op;
        logic [XLEN-1:0] operand;
    } csr_req_t;

endpackage

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic clk,
    input  logic rst,
    input  logic redirect_i,
    input  logic [core_pkg::XLEN-1:0] target_i,
    output logic [core_pkg::XLEN-1:0] pc_o,
    output logic [core_pkg::XLEN-1:0] fetch_pc_o
);

    logic [core_pkg::XLEN-1:0] pc_q;
    logic [core_pkg::XLEN-1:0] fetch_pc_q;

    // taken branch or jump from execute overrides sequential fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= core_pkg::RESET_PC;
        end else if (redirect_i) begin
            pc_q <= target_i;
        end else begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // pc of the word the rom returns this cycle
    always_ff @(posedge clk) begin
        fetch_pc_q <= pc_q;
    end

    assign pc_o = pc_q;
    assign fetch_pc_o = fetch_pc_q;

endmodule

/* decode/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  core_pkg::inst_u inst_i,
    output core_pkg::decoded_t decoded_o,
    output logic [core_pkg::XLEN-1:0] imm_o,
    output logic [4:0] rs1_o,
    output logic [4:0] rs2_o,
    output logic [4:0] rd_o
);

    // shared by register and immediate forms
    function automatic core_pkg::alu_op_e alu_from_funct3(
        input logic [2:0] funct3,
        input logic alt
    );
        core_pkg::alu_op_e op;
        case (funct3)
            3'b000: op = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001: op = core_pkg::ALU_SLL;
            3'b010: op = core_pkg::ALU_SLT;
            3'b011: op = core_pkg::ALU_SLTU;
            3'b100: op = core_pkg::ALU_XOR;
            3'b101: op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110: op = core_pkg::ALU_OR;
            default: op = core_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        decoded_o = '0;
        imm_o = '0;
        case (inst_i.r.opcode)
            core_pkg::OP: begin
                decoded_o.rd_we = 1'b1;
                decoded_o.alu_op = alu_from_funct3(inst_i.r.funct3, inst_i.r.funct7[5]);
            end
            core_pkg::OP_IMM: begin
                decoded_o.rd_we = 1'b1;
                decoded_o.uses_imm = 1'b1;
                // only srai looks at bit 30
                decoded_o.alu_op = alu_from_funct3(inst_i.i.funct3,
                    (inst_i.i.funct3 == 3'b101) && inst_i.r.funct7[5]);
                imm_o = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
            end
            core_pkg::LUI: begin
                decoded_o.rd_we = 1'b1;
                decoded_o.uses_imm = 1'b1;
                decoded_o.alu_op = core_pkg::ALU_PASS_B;
                imm_o = {inst_i.u.imm, 12'h000};
            end
            core_pkg::JAL: begin
                decoded_o.rd_we = 1'b1;
                decoded_o.is_jump = 1'b1;
                decoded_o.wb_sel = core_pkg::WB_PC4;
                imm_o = {{11{inst_i.j.imm20}}, inst_i.j.imm20, inst_i.j.imm19_12,
                         inst_i.j.imm11, inst_i.j.imm10_1, 1'b0};
            end
            core_pkg::BRANCH: begin
                decoded_o.is_branch = 1'b1;
                imm_o = {{19{inst_i.b.imm12}}, inst_i.b.imm12, inst_i.b.imm11,
                         inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
            end
            core_pkg::STORE: begin
                decoded_o.is_store = 1'b1;
                decoded_o.uses_imm = 1'b1;
                imm_o = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
            end
            core_pkg::SYSTEM: begin
                if (inst_i.i.funct3[1:0] != 2'b00) begin
                    decoded_o.rd_we = 1'b1;
                    decoded_o.wb_sel = core_pkg::WB_CSR;
                    decoded_o.csr_uses_imm = inst_i.i.funct3[2];
                    decoded_o.csr_op = core_pkg::csr_op_e'(inst_i.i.funct3[1:0]);
                    // set/clear with a zero source is a pure read
                    if (inst_i.i.funct3[1] && (inst_i.i.rs1 == 5'd0)) begin
                        decoded_o.csr_op = core_pkg::CSR_NONE;
                    end
                end
            end
            default: ;
        endcase
    end

    assign rs1_o = inst_i.r.rs1;
    assign rs2_o = inst_i.r.rs2;
    assign rd_o = inst_i.r.rd;

endmodule

/* decode/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic clk,
    input  logic [4:0] rs1_i,
    input  logic [4:0] rs2_i,
    output logic [core_pkg::XLEN-1:0] rs1_data_o,
    output logic [core_pkg::XLEN-1:0] rs2_data_o,
    input  logic we_i,
    input  logic [4:0] rd_i,
    input  logic [core_pkg::XLEN-1:0] rd_data_i
);

    logic [core_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (we_i && (rd_i != 5'd0)) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    // x0 is never written, force zero on read
    assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

/* execute/csr_file.sv */
`timescale 1ns/1ps

module csr_file (
    input  logic clk,
    input  logic rst,
    input  core_pkg::csr_req_t req_i,
    input  logic retire_i,
    output logic [core_pkg::XLEN-1:0] rdata_o
);

    logic [core_pkg::XLEN-1:0] mscratch;
    logic [63:0] mcycle;
    logic [63:0] minstret;
    logic [core_pkg::XLEN-1:0] wdata;
    logic we;

    // a write to either half wins over the increment
    function automatic logic [63:0] count_next(
        input logic [63:0] cur,
        input logic hit_lo,
        input logic hit_hi,
        input logic [core_pkg::XLEN-1:0] value,
        input logic inc
    );
        logic [63:0] nxt;
        nxt = cur + {63'd0, inc};
        if (hit_lo) begin
            nxt = {cur[63:32], value};
        end else if (hit_hi) begin
            nxt = {value, cur[31:0]};
        end
        return nxt;
    endfunction

    always_comb begin
        case (req_i.addr)
            core_pkg::CSR_MSCRATCH: rdata_o = mscratch;
            core_pkg::CSR_MCYCLE: rdata_o = mcycle[31:0];
            core_pkg::CSR_MCYCLEH: rdata_o = mcycle[63:32];
            core_pkg::CSR_MINSTRET: rdata_o = minstret[31:0];
            core_pkg::CSR_MINSTRETH: rdata_o = minstret[63:32];
            default: rdata_o = '0;
        endcase
    end

    // set and clear act on the value read this cycle
    always_comb begin
        case (req_i.op)
            core_pkg::CSR_SET: wdata = rdata_o | req_i.operand;
            core_pkg::CSR_CLEAR: wdata = rdata_o & ~req_i.operand;
            default: wdata = req_i.operand;
        endcase
    end

    assign we = req_i.valid && (req_i.op != core_pkg::CSR_NONE);

    always_ff @(posedge clk) begin
        if (we && (req_i.addr == core_pkg::CSR_MSCRATCH)) begin
            mscratch <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
            minstret <= '0;
        end else begin
            mcycle <= count_next(mcycle, we && (req_i.addr == core_pkg::CSR_MCYCLE),
                we && (req_i.addr == core_pkg::CSR_MCYCLEH), wdata, 1'b1);
            minstret <= count_next(minstret, we && (req_i.addr == core_pkg::CSR_MINSTRET),
                we && (req_i.addr == core_pkg::CSR_MINSTRETH), wdata, retire_i);
        end
    end

endmodule

/* execute/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic clk,
    input  logic rst,
    input  core_pkg::dec_exe_t stage_i,
    output logic [core_pkg::XLEN-1:0] wb_data_o,
    output logic [4:0] wb_rd_o,
    output logic wb_we_o,
    output logic redirect_o,
    output logic [core_pkg::XLEN-1:0] target_o,
    output logic uart_tx_valid_o,
    output logic [7:0] uart_tx_data_o
);

    logic [core_pkg::XLEN-1:0] op_a;
    logic [core_pkg::XLEN-1:0] op_b;
    logic [core_pkg::XLEN-1:0] alu_res;
    logic [core_pkg::XLEN-1:0] csr_rdata;
    logic [2:0] funct3;
    logic eq;
    logic lt;
    logic taken;
    logic uart_hit;
    logic tx_valid_q;
    logic [7:0] tx_data_q;
    core_pkg::csr_req_t csr_req;

    // --------------------------------------------------------------------------
    // alu
    assign op_a = stage_i.rs1_data;
    assign op_b = stage_i.decoded.uses_imm ? stage_i.imm : stage_i.rs2_data;

    always_comb begin
        case (stage_i.decoded.alu_op)
            core_pkg::ALU_SUB: alu_res = op_a - op_b;
            core_pkg::ALU_AND: alu_res = op_a & op_b;
            core_pkg::ALU_OR: alu_res = op_a | op_b;
            core_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            core_pkg::ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            core_pkg::ALU_SLTU: alu_res = {31'd0, op_a < op_b};
            core_pkg::ALU_SLL: alu_res = op_a << op_b[4:0];
            core_pkg::ALU_SRL: alu_res = op_a >> op_b[4:0];
            core_pkg::ALU_SRA: alu_res = $signed(op_a) >>> op_b[4:0];
            core_pkg::ALU_PASS_B: alu_res = op_b;
            default: alu_res = op_a + op_b;
        endcase
    end

    // --------------------------------------------------------------------------
    // branch compare, funct3[1] picks unsigned, funct3[0] inverts
    assign funct3 = stage_i.inst.b.funct3;
    assign eq = (stage_i.rs1_data == stage_i.rs2_data);
    assign lt = funct3[1] ? (stage_i.rs1_data < stage_i.rs2_data)
                          : ($signed(stage_i.rs1_data) < $signed(stage_i.rs2_data));
    assign taken = funct3[2] ? (lt ^ funct3[0]) : (eq ^ funct3[0]);

    assign redirect_o = stage_i.valid
        && (stage_i.decoded.is_jump || (stage_i.decoded.is_branch && taken));
    assign target_o = stage_i.pc + stage_i.imm;

    // --------------------------------------------------------------------------
    // csr access, imm form uses the rs1 field zero-extended
    assign csr_req.valid = stage_i.valid;
    assign csr_req.addr = stage_i.inst.i.imm;
    assign csr_req.op = stage_i.decoded.csr_op;
    assign csr_req.operand = stage_i.decoded.csr_uses_imm
        ? {27'd0, stage_i.inst.r.rs1} : stage_i.rs1_data;

    csr_file u_csr (
        .clk     (clk),
        .rst     (rst),
        .req_i   (csr_req),
        .retire_i(stage_i.valid),
        .rdata_o (csr_rdata)
    );

    always_comb begin
        case (stage_i.decoded.wb_sel)
            core_pkg::WB_PC4: wb_data_o = stage_i.pc + 32'd4;
            core_pkg::WB_CSR: wb_data_o = csr_rdata;
            default: wb_data_o = alu_res;
        endcase
    end

    assign wb_rd_o = stage_i.inst.r.rd;
    assign wb_we_o = stage_i.valid && stage_i.decoded.rd_we;

    // --------------------------------------------------------------------------
    // uart transmit, one-cycle strobe
    assign uart_hit = stage_i.valid && stage_i.decoded.is_store
        && (alu_res[19:16] == core_pkg::MMIO_RANGE)
        && (alu_res[4:2] == core_pkg::UART_TX_OFFSET);

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid_q <= 1'b0;
        end else begin
            tx_valid_q <= uart_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (uart_hit) begin
            tx_data_q <= stage_i.rs2_data[7:0];
        end
    end

    assign uart_tx_valid_o = tx_valid_q;
    assign uart_tx_data_o = tx_data_q;

endmodule

/* logic/core_top.sv */
`timescale 1ns/1ps

module core_top (
    input  logic clk,
    input  logic rst,
    output logic [core_pkg::XLEN-1:0] pc_o,
    input  logic [core_pkg::XLEN-1:0] inst_i,
    output logic uart_tx_valid_o,
    output logic [7:0] uart_tx_data_o,
    output logic inst_retired_o
);

    logic [core_pkg::XLEN-1:0] fetch_pc;
    logic redirect;
    logic [core_pkg::XLEN-1:0] target;
    core_pkg::decoded_t decoded;
    logic [core_pkg::XLEN-1:0] imm;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [core_pkg::XLEN-1:0] rs1_data;
    logic [core_pkg::XLEN-1:0] rs2_data;
    logic [core_pkg::XLEN-1:0] wb_data;
    logic [4:0] wb_rd;
    logic wb_we;
    logic [1:0] rst_seq;
    logic kill_q;
    logic dec_valid;
    logic retired_q;
    core_pkg::dec_exe_t dec_exe_q;
    core_pkg::dec_exe_t exe_in;

    fetch_unit u_fetch (
        .clk       (clk),
        .rst       (rst),
        .redirect_i(redirect),
        .target_i  (target),
        .pc_o      (pc_o),
        .fetch_pc_o(fetch_pc)
    );

    decoder u_decoder (
        .inst_i   (inst_i),
        .decoded_o(decoded),
        .imm_o    (imm),
        .rs1_o    (rs1),
        .rs2_o    (rs2),
        .rd_o     ()
    );

    reg_file u_rf (
        .clk       (clk),
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data),
        .we_i      (wb_we),
        .rd_i      (wb_rd),
        .rd_data_i (wb_data)
    );

    // --------------------------------------------------------------------------
    // pipeline control
    // bit 0 drops the stale word in decode, bit 1 masks execute
    always_ff @(posedge clk) begin
        if (rst) begin
            rst_seq <= 2'b11;
            kill_q <= 1'b0;
        end else begin
            rst_seq <= {rst_seq[0], 1'b0};
            kill_q <= redirect;
        end
    end

    // a redirect kills the words now in decode and arriving next cycle
    assign dec_valid = !rst_seq[0] && !redirect && !kill_q;

    // --------------------------------------------------------------------------
    // decode/execute register, execute result bypassed into decode
    always_ff @(posedge clk) begin
        dec_exe_q.valid <= dec_valid;
        dec_exe_q.pc <= fetch_pc;
        dec_exe_q.inst <= inst_i;
        dec_exe_q.decoded <= decoded;
        dec_exe_q.rs1_data <= (wb_we && (wb_rd == rs1) && (wb_rd != 5'd0))
            ? wb_data : rs1_data;
        dec_exe_q.rs2_data <= (wb_we && (wb_rd == rs2) && (wb_rd != 5'd0))
            ? wb_data : rs2_data;
        dec_exe_q.imm <= imm;
        if (rst) begin
            dec_exe_q.valid <= 1'b0;
        end
    end

    always_comb begin
        exe_in = dec_exe_q;
        exe_in.valid = dec_exe_q.valid && !rst_seq[1];
    end

    execute_stage u_exe (
        .clk            (clk),
        .rst            (rst),
        .stage_i        (exe_in),
        .wb_data_o      (wb_data),
        .wb_rd_o        (wb_rd),
        .wb_we_o        (wb_we),
        .redirect_o     (redirect),
        .target_o       (target),
        .uart_tx_valid_o(uart_tx_valid_o),
        .uart_tx_data_o (uart_tx_data_o)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            retired_q <= 1'b0;
        end else begin
            retired_q <= exe_in.valid;
        end
    end

    assign inst_retired_o = retired_q;

endmodule

/* tb/core_checker.sv */
`timescale 1ns/1ps

module core_checker (
    input logic clk,
    input logic rst,
    input logic [core_pkg::XLEN-1:0] pc_i,
    input logic uart_valid_i,
    input logic [7:0] uart_data_i,
    input logic retired_i,
    input logic exe_valid_i,
    input logic redirect_i
);

    // failures seen so far, read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // ------------------------------------------------------------------------
    // uart bytes
    // killed wrong-path stores carry the marker 0xee
    assert property (@(posedge clk) disable iff (rst)
        uart_valid_i |-> (uart_data_i != 8'hEE))
    else begin
        $error("wrong-path store reached the UART");
        fail_count++;
    end

    // ------------------------------------------------------------------------
    // reset flush
    assert property (@(posedge clk) $fell(rst) |-> (pc_i == core_pkg::RESET_PC))
    else begin
        $error("first fetch after reset not at the reset address");
        fail_count++;
    end

    assert property (@(posedge clk) $fell(rst) |-> (!exe_valid_i) [*2])
    else begin
        $error("execute stage valid during reset flush");
        fail_count++;
    end

    assert property (@(posedge clk) $fell(rst) |-> (!retired_i && !uart_valid_i) [*3])
    else begin
        $error("retire or UART strobe too early after reset");
        fail_count++;
    end

    // the two words behind a taken branch or jump never retire
    assert property (@(posedge clk) disable iff (rst)
        ($past(redirect_i, 2) || $past(redirect_i, 3)) |-> !retired_i)
    else begin
        $error("killed instruction raised the retire pulse");
        fail_count++;
    end

endmodule

bind core_top core_checker u_chk (
    .clk         (clk),
    .rst         (rst),
    .pc_i        (pc_o),
    .uart_valid_i(uart_tx_valid_o),
    .uart_data_i (uart_tx_data_o),
    .retired_i   (inst_retired_o),
    .exe_valid_i (exe_in.valid),
    .redirect_i  (redirect)
);

/* tb/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

    localparam int NUM_BYTES = 15;
    localparam int WIN_OPEN_IDX = 12;
    localparam int WIN_CLOSE_IDX = 13;
    localparam int INSTRET_IDX = 14;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int MCYCLE_GAP = 2;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [31:0] inst_q = '0;
    logic [31:0] pc;
    logic uart_valid;
    logic [7:0] uart_data;
    logic retired;

    logic [31:0] rom [64];
    logic [7:0] expected [NUM_BYTES];
    int n_words = 0;
    int jal_idx = 0;
    int n_bytes = 0;
    int errors = 0;
    int win_count = 0;
    bit in_window = 0;

    core_top dut (
        .clk            (clk),
        .rst            (rst),
        .pc_o           (pc),
        .inst_i         (inst_q),
        .uart_tx_valid_o(uart_valid),
        .uart_tx_data_o (uart_data),
        .inst_retired_o (retired)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // instruction encoders
    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] w);
        rom[n_words] = w;
        n_words++;
    endtask

    task automatic build_program();
        logic [31:0] nop;
        logic [31:0] kill;
        nop = itype(12'd0, 5'd0, 3'b000, 5'd0, 7'b0010011);
        kill = stype(12'd0, 5'd6, 5'd31);
        // uart base 0x80000 in x31
        emit({20'h00080, 5'd31, 7'b0110111});
        // dependent alu chain
        emit(itype(12'h023, 5'd0, 3'b000, 5'd1, 7'b0010011));
        emit(rtype(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
        emit(rtype(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));
        emit(rtype(7'h00, 5'd2, 5'd3, 3'b100, 5'd4));
        emit(rtype(7'h00, 5'd1, 5'd4, 3'b001, 5'd5));
        for (int r = 1; r <= 5; r++) begin
            emit(stype(12'd0, r[4:0], 5'd31));
        end
        emit(itype(12'h0EE, 5'd0, 3'b000, 5'd6, 7'b0010011));
        emit(itype(12'hFFF, 5'd0, 3'b000, 5'd7, 7'b0010011));
        // taken beq, blt, bltu and jal, each followed by two marker stores
        emit(btype(13'd12, 5'd0, 5'd0, 3'b000));
        emit(kill);
        emit(kill);
        emit(btype(13'd12, 5'd0, 5'd7, 3'b100));
        emit(kill);
        emit(kill);
        emit(btype(13'd12, 5'd7, 5'd0, 3'b110));
        emit(kill);
        emit(kill);
        jal_idx = n_words;
        emit(jtype(21'd12, 5'd8));
        emit(kill);
        emit(kill);
        emit(stype(12'd0, 5'd8, 5'd31));
        // untaken bne and bge
        emit(btype(13'd8, 5'd0, 5'd0, 3'b001));
        emit(itype(12'h011, 5'd0, 3'b000, 5'd9, 7'b0010011));
        emit(stype(12'd0, 5'd9, 5'd31));
        emit(btype(13'd8, 5'd0, 5'd7, 3'b101));
        emit(itype(12'h022, 5'd0, 3'b000, 5'd9, 7'b0010011));
        emit(stype(12'd0, 5'd9, 5'd31));
        // mscratch read-modify-write
        emit(itype(12'h05A, 5'd0, 3'b000, 5'd10, 7'b0010011));
        emit(itype(12'h001, 5'd0, 3'b000, 5'd12, 7'b0010011));
        emit(itype(12'h340, 5'd10, 3'b001, 5'd0, 7'b1110011));
        emit(itype(12'h340, 5'd12, 3'b010, 5'd11, 7'b1110011));
        emit(itype(12'h340, 5'd2, 3'b111, 5'd13, 7'b1110011));
        emit(itype(12'h340, 5'd0, 3'b010, 5'd14, 7'b1110011));
        emit(stype(12'd0, 5'd11, 5'd31));
        emit(stype(12'd0, 5'd13, 5'd31));
        emit(stype(12'd0, 5'd14, 5'd31));
        // mcycle spacing
        emit(itype(12'hB00, 5'd0, 3'b010, 5'd15, 7'b1110011));
        for (int k = 0; k < MCYCLE_GAP; k++) begin
            emit(nop);
        end
        emit(itype(12'hB00, 5'd0, 3'b010, 5'd16, 7'b1110011));
        emit(rtype(7'h20, 5'd15, 5'd16, 3'b000, 5'd17));
        emit(stype(12'd0, 5'd17, 5'd31));
        // stores outside the uart register
        emit(stype(12'd0, 5'd6, 5'd0));
        emit(stype(12'd4, 5'd6, 5'd31));
        // minstret window between two marker bytes
        emit(itype(12'h0A1, 5'd0, 3'b000, 5'd20, 7'b0010011));
        emit(itype(12'h0A2, 5'd0, 3'b000, 5'd21, 7'b0010011));
        emit(stype(12'd0, 5'd20, 5'd31));
        emit(itype(12'hB02, 5'd0, 3'b010, 5'd18, 7'b1110011));
        emit(btype(13'd12, 5'd0, 5'd0, 3'b000));
        emit(kill);
        emit(kill);
        emit(nop);
        emit(itype(12'hB02, 5'd0, 3'b010, 5'd19, 7'b1110011));
        emit(stype(12'd0, 5'd21, 5'd31));
        emit(rtype(7'h20, 5'd18, 5'd19, 3'b000, 5'd22));
        emit(stype(12'd0, 5'd22, 5'd31));
        emit(jtype(21'd0, 5'd0));
    endtask

    task automatic build_expected();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        logic [31:0] v4;
        logic [31:0] scratch;
        v1 = 32'h23;
        v2 = v1 + v1;
        v3 = v2 - v1;
        v4 = v3 ^ v2;
        expected[0] = v1[7:0];
        expected[1] = v2[7:0];
        expected[2] = v3[7:0];
        expected[3] = v4[7:0];
        expected[4] = 8'((v4 << v1[4:0]) & 32'hFF);
        expected[5] = 8'(jal_idx * 4 + 4);
        expected[6] = 8'h11;
        expected[7] = 8'h22;
        scratch = 32'h5A;
        expected[8] = scratch[7:0];
        scratch = scratch | 32'h1;
        expected[9] = scratch[7:0];
        scratch = scratch & ~32'h2;
        expected[10] = scratch[7:0];
        // mcycle advances once per cycle, one cycle per instruction
        expected[11] = 8'(MCYCLE_GAP + 1);
        expected[12] = 8'hA1;
        expected[13] = 8'hA2;
        expected[14] = 8'h00;
    endtask

    // ------------------------------------------------------------------------
    // rom with one cycle latency
    always @(posedge clk) begin
        inst_q <= rom[pc[7:2]];
    end

    // uart capture and retire counting between the window markers
    always @(posedge clk) begin
        logic [7:0] want;
        if (!rst) begin
            if (uart_valid && n_bytes == WIN_CLOSE_IDX) begin
                in_window = 0;
            end
            if (in_window && retired) begin
                win_count++;
            end
            if (uart_valid && n_bytes == WIN_OPEN_IDX) begin
                in_window = 1;
            end
            if (uart_valid) begin
                // second minstret read retires inside the window too
                want = (n_bytes == INSTRET_IDX) ? 8'(win_count - 1)
                     : (n_bytes < NUM_BYTES) ? expected[n_bytes] : 8'hXX;
                assert (n_bytes < NUM_BYTES && uart_data == want)
                else begin
                    $display("Fail at %0t: UART byte %0d is %h, expected %h",
                             $time, n_bytes, uart_data, want);
                    errors++;
                end
                n_bytes++;
            end
        end
    end

    initial begin
        int cycles;
        int total;
        for (int a = 0; a < 64; a++) begin
            rom[a] = itype(a[11:0], 5'd0, 3'b000, 5'd0, 7'b0010011);
        end
        build_program();
        build_expected();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while (n_bytes < NUM_BYTES && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (n_bytes < NUM_BYTES) begin
            $display("timeout: only %0d of %0d UART bytes arrived", n_bytes, NUM_BYTES);
            errors++;
        end
        repeat (2) @(posedge clk);
        total = errors + int'(dut.u_chk.fail_count);
        $display("errors %0d, assertion failures %0d, UART bytes %0d",
                 errors, dut.u_chk.fail_count, n_bytes);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
common/core_pkg.sv
logic/fetch_unit.sv
decode/decoder.sv
decode/reg_file.sv
execute/csr_file.sv
execute/execute_stage.sv
logic/core_top.sv
tb/core_checker.sv
tb/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= core_tb
BUILD_DIR ?= obj_dir
FILELIST ?= files.f
VFLAGS ?= --binary --timing --assert -Wall -Wno-fatal
PASS_TEXT ?= TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
